/* Bender.yml */
package:
  name: hyper_axi_front

sources:
  - files:
      - hdl/hyper_axi_pkg.sv
      - hdl/hyper_phy_pkg.sv
      - hdl/hyper_ax_arbiter.sv
      - hdl/hyper_trans_mapper.sv
      - hdl/hyper_stream_fifo.sv
      - hdl/hyper_trans_status.sv
      - hdl/hyper_axi_front.sv
  - target: simulation
    files:
      - dv/tb_hyper_axi_front.sv

/* dv/tb_hyper_axi_front.sv */
/* Testbench for the HyperBus front end with AXI-side and PHY-side models.
   Runs directed and random transfers and checks descriptors, beats and responses. */

`timescale 1ns/100ps

module tb_hyper_axi_front;

    import hyper_axi_pkg::*;
    import hyper_phy_pkg::*;

    localparam int ClkPeriod = 40;
    localparam int NumTrans  = 21;
    localparam int MaxBeats  = 8;
    localparam int Timeout   = NumTrans * MaxBeats * ClkPeriod * 4 + 4000;

    logic                      clk_i;
    logic                      rst_ni;
    ax_t                       ar_i;
    logic                      ar_valid_i;
    logic                      ar_ready_o;
    ax_t                       aw_i;
    logic                      aw_valid_i;
    logic                      aw_ready_o;
    w_beat_t                   w_i;
    logic                      w_valid_i;
    logic                      w_ready_o;
    r_beat_t                   r_o;
    logic                      r_valid_o;
    logic                      r_ready_i;
    resp_t                     b_resp_o;
    logic                      b_valid_o;
    logic                      b_ready_i;
    rx_t                       rx_i;
    logic                      rx_valid_i;
    logic                      rx_ready_o;
    tx_t                       tx_o;
    logic                      tx_valid_o;
    logic                      tx_ready_i;
    logic                      b_error_i;
    logic                      phy_b_valid_i;
    logic                      phy_b_ready_o;
    trans_t                    trans_o;
    logic [NumChips-1:0]       trans_cs_o;
    logic                      trans_valid_o;
    logic                      trans_ready_i;
    chip_rule_t [NumChips-1:0] chip_rules_i;
    logic [4:0]                addr_mask_msb_i;
    logic                      addr_space_i;
    logic                      trans_active_o;

    int seed = 32'h1be77de7;
    int errors = 0;
    int checks = 0;
    int test_start_errors;
    logic wr_open = 1'b0;

    // Expected descriptors, read beats and transmit beats in order
    req_t    desc_q[$];
    r_beat_t r_exp_q[$];
    tx_t     tx_exp_q[$];

    hyper_axi_front UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk_i = ~clk_i;
        end
    end

    // ====================
    // Reference model
    // ====================

    // Expected descriptor for full-width beats of two words each
    function automatic trans_t ref_trans(input ax_t ax, input logic wr);
        trans_t t;
        logic [31:0] masked;
        masked          = ax.addr & 32'h00FF_FFFF;
        t.write         = wr;
        t.burst_type    = 1'b1;
        t.address_space = addr_space_i;
        t.address       = masked / 4;
        t.burst         = (blen_t'(ax.len) + 16'd1) * 16'd2;
        return t;
    endfunction

    // Chip 0 below 8 MiB and chip 1 up to 16 MiB
    function automatic logic [NumChips-1:0] ref_cs(input logic [31:0] addr);
        if (addr < 32'h0080_0000) begin
            return 2'b01;
        end else if (addr < 32'h0100_0000) begin
            return 2'b10;
        end
        return 2'b01;
    endfunction

    // About half the addresses land inside the chip window
    function automatic ax_t rand_ax();
        ax_t ax;
        ax.addr = $random(seed) & 32'h01FF_FFFF;
        ax.len  = $random(seed) & 8'h07;
        ax.size = 3'd2;
        return ax;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ====================
    // Checker
    // ====================

    always @(negedge clk_i) begin
        if (rst_ni) begin
            checks++;
            assert (!(trans_active_o && trans_valid_o))
            else report_mismatch("descriptor offered while a transfer is active");
            checks++;
            assert (!tx_valid_o || wr_open)
            else report_mismatch("tx beat outside an accepted write");
            if (tx_valid_o && tx_ready_i && tx_o.last) begin
                wr_open = 1'b0;
            end
            if (trans_valid_o && trans_ready_i) begin
                checks++;
                assert (desc_q.size() != 0)
                else report_mismatch("descriptor handshake with no request pending");
                if (desc_q.size() != 0) begin
                    req_t rq;
                    rq = desc_q.pop_front();
                    checks++;
                    assert (trans_o == ref_trans(rq.ax, rq.write))
                    else report_mismatch($sformatf("descriptor %h, expected %h",
                                                   trans_o, ref_trans(rq.ax, rq.write)));
                    checks++;
                    assert (trans_cs_o == ref_cs(rq.ax.addr))
                    else report_mismatch($sformatf("chip select %b for address %h",
                                                   trans_cs_o, rq.ax.addr));
                    if (rq.write) begin
                        wr_open = 1'b1;
                    end
                end
            end
        end
    end

    // ====================
    // AXI and PHY models
    // ====================

    task automatic send_ar(input ax_t ax);
        ar_i       = ax;
        ar_valid_i = 1'b1;
        do @(negedge clk_i); while (!ar_ready_o);
        @(posedge clk_i);
        #2 ar_valid_i = 1'b0;
    endtask

    task automatic send_aw(input ax_t ax);
        aw_i       = ax;
        aw_valid_i = 1'b1;
        do @(negedge clk_i); while (!aw_ready_o);
        @(posedge clk_i);
        #2 aw_valid_i = 1'b0;
    endtask

    task automatic do_read(input ax_t ax, input bit send_addr, input bit stall);
        int beats;
        beats = ax.len + 1;
        if (stall) begin
            r_ready_i = 1'b0;
        end
        fork
            if (send_addr) begin
                send_ar(ax);
            end
            begin
                rx_t bt;
                do @(negedge clk_i); while (!trans_active_o);
                @(posedge clk_i);
                #2;
                for (int i = 0; i < beats; i++) begin
                    bt.data  = $random(seed);
                    bt.error = $random(seed) & 1;
                    bt.last  = (i == beats - 1);
                    rx_i       = bt;
                    rx_valid_i = 1'b1;
                    do @(negedge clk_i); while (!rx_ready_o);
                    @(posedge clk_i);
                    r_exp_q.push_back('{bt.data, bt.error ? 2'd2 : 2'd0, bt.last});
                    #2;
                end
                rx_valid_i = 1'b0;
                @(negedge clk_i);
                checks++;
                assert (!trans_active_o)
                else report_mismatch("transfer still active after last rx beat");
            end
            begin
                r_beat_t exp;
                if (stall) begin
                    repeat (8) @(posedge clk_i);
                    @(negedge clk_i);
                    checks++;
                    assert (!rx_ready_o && r_exp_q.size() == 2)
                    else report_mismatch("rx_ready_o not dropped after two held beats");
                    @(posedge clk_i);
                    #2 r_ready_i = 1'b1;
                end
                for (int i = 0; i < beats; i++) begin
                    do @(negedge clk_i); while (!(r_valid_o && r_ready_i));
                    exp = r_exp_q.pop_front();
                    checks++;
                    assert (r_o == exp)
                    else report_mismatch($sformatf("read beat %h, expected %h", r_o, exp));
                    @(posedge clk_i);
                    #2;
                end
            end
        join
    endtask

    task automatic do_write(input ax_t ax, input bit send_addr, input bit err);
        int beats;
        beats = ax.len + 1;
        fork
            if (send_addr) begin
                send_aw(ax);
            end
            begin
                w_beat_t wb;
                for (int i = 0; i < beats; i++) begin
                    wb.data = $random(seed);
                    wb.strb = $random(seed);
                    wb.last = (i == beats - 1);
                    w_i       = wb;
                    w_valid_i = 1'b1;
                    tx_exp_q.push_back('{wb.data, wb.strb, wb.last});
                    do @(negedge clk_i); while (!w_ready_o);
                    @(posedge clk_i);
                    #2;
                end
                w_valid_i = 1'b0;
            end
            begin
                tx_t exp;
                for (int i = 0; i < beats; i++) begin
                    do @(negedge clk_i); while (!(tx_valid_o && tx_ready_i));
                    exp = tx_exp_q.pop_front();
                    checks++;
                    assert (tx_o == exp)
                    else report_mismatch($sformatf("tx beat %h, expected %h", tx_o, exp));
                    @(posedge clk_i);
                    #2;
                end
                // Response held one cycle with the AXI side not ready
                b_error_i     = err;
                phy_b_valid_i = 1'b1;
                b_ready_i     = 1'b0;
                @(negedge clk_i);
                checks++;
                assert (b_valid_o && !phy_b_ready_o && b_resp_o == (err ? 2'd2 : 2'd0))
                else report_mismatch($sformatf("write response valid %0b ready %0b code %0d, error %0b",
                                               b_valid_o, phy_b_ready_o, b_resp_o, err));
                @(posedge clk_i);
                #2 b_ready_i = 1'b1;
                @(negedge clk_i);
                checks++;
                assert (phy_b_ready_o && trans_active_o)
                else report_mismatch("response ready not passed on or transfer ended early");
                @(posedge clk_i);
                #2 phy_b_valid_i = 1'b0;
                @(negedge clk_i);
                checks++;
                assert (!trans_active_o)
                else report_mismatch("transfer still active after write response");
                @(posedge clk_i);
                #2;
            end
        join
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        ax_t a;
        ax_t b;
        ax_t c;
        ax_t d;
        rst_ni = 1'b0;
        ar_i = '0;
        aw_i = '0;
        w_i = '0;
        rx_i = '0;
        ar_valid_i = 1'b0;
        aw_valid_i = 1'b0;
        w_valid_i = 1'b0;
        rx_valid_i = 1'b0;
        r_ready_i = 1'b1;
        b_ready_i = 1'b1;
        tx_ready_i = 1'b1;
        trans_ready_i = 1'b1;
        b_error_i = 1'b0;
        phy_b_valid_i = 1'b0;
        addr_space_i = 1'b0;
        addr_mask_msb_i = 5'd24;
        chip_rules_i[0].idx = 1'b0;
        chip_rules_i[0].start_addr = 32'h0000_0000;
        chip_rules_i[0].end_addr   = 32'h0080_0000;
        chip_rules_i[1].idx = 1'b1;
        chip_rules_i[1].start_addr = 32'h0080_0000;
        chip_rules_i[1].end_addr   = 32'h0100_0000;
        repeat (4) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        test_start_errors = 0;

        // Both channels stay valid so the grant has to alternate
        a = rand_ax();
        b = rand_ax();
        c = rand_ax();
        d = rand_ax();
        desc_q.push_back('{a, 1'b0});
        desc_q.push_back('{b, 1'b1});
        desc_q.push_back('{c, 1'b0});
        desc_q.push_back('{d, 1'b1});
        fork
            begin
                send_ar(a);
                send_ar(c);
            end
            begin
                send_aw(b);
                send_aw(d);
            end
            begin
                do_read(a, 1'b0, 1'b0);
                do_write(b, 1'b0, 1'b0);
                do_read(c, 1'b0, 1'b0);
                do_write(d, 1'b0, 1'b0);
            end
        join
        end_test("arbitration");

        for (int k = 0; k < 8; k++) begin
            a = rand_ax();
            addr_space_i = k[1];
            desc_q.push_back('{a, k[0]});
            if (k[0]) begin
                do_write(a, 1'b1, $random(seed) & 1);
            end else begin
                do_read(a, 1'b1, 1'b0);
            end
        end
        end_test("descriptor mapping");

        // Write request waits behind an active read
        a = rand_ax();
        a.len = 8'd4;
        b = rand_ax();
        desc_q.push_back('{a, 1'b0});
        desc_q.push_back('{b, 1'b1});
        fork
            do_read(a, 1'b1, 1'b0);
            begin
                do @(negedge clk_i); while (!trans_active_o);
                @(posedge clk_i);
                #2 send_aw(b);
            end
        join
        do_write(b, 1'b0, 1'b0);

        // Read request waits behind an active write
        a = rand_ax();
        a.len = 8'd4;
        b = rand_ax();
        desc_q.push_back('{a, 1'b1});
        desc_q.push_back('{b, 1'b0});
        fork
            do_write(a, 1'b1, 1'b0);
            begin
                do @(negedge clk_i); while (!trans_active_o);
                @(posedge clk_i);
                #2 send_ar(b);
            end
        join
        do_read(b, 1'b0, 1'b0);
        end_test("exclusivity");

        a = rand_ax();
        desc_q.push_back('{a, 1'b1});
        trans_ready_i = 1'b0;
        fork
            do_write(a, 1'b1, 1'b0);
            begin
                repeat (6) @(posedge clk_i);
                #2 trans_ready_i = 1'b1;
            end
        join
        end_test("write data");

        a = rand_ax();
        desc_q.push_back('{a, 1'b0});
        do_read(a, 1'b1, 1'b0);
        a = rand_ax();
        a.len = 8'd5;
        desc_q.push_back('{a, 1'b0});
        do_read(a, 1'b1, 1'b1);
        end_test("read back-pressure");

        for (int k = 0; k < 2; k++) begin
            a = rand_ax();
            desc_q.push_back('{a, 1'b1});
            do_write(a, 1'b1, k == 0);
        end
        end_test("write response");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(Timeout);
        $display("Timeout: the tests did not finish within %0d ns", Timeout);
        $display("Checks failed");
        $finish;
    end

endmodule

/* hdl/hyper_ax_arbiter.sv */
/* Round-robin arbiter between AR and AW requests feeding a two-entry
   spill register, so the bus sees one request stream tagged with a write flag. */

`timescale 1ns/100ps

module hyper_ax_arbiter (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  hyper_axi_pkg::ax_t  ar_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,

    input  hyper_axi_pkg::ax_t  aw_i,
    input  logic                aw_valid_i,
    output logic                aw_ready_o,

    output hyper_phy_pkg::req_t req_o,
    output logic                req_valid_o,
    input  logic                req_ready_i
);

    import hyper_phy_pkg::*;

    // Grant state, high when AW won the last handshake
    logic last_aw_q;
    logic sel_aw;
    logic arb_valid;
    logic spill_ready;
    req_t arb_req;

    // Spill register stages
    logic a_full_q;
    logic b_full_q;
    req_t a_data_q;
    req_t b_data_q;
    logic a_fill;
    logic a_drain;
    logic b_fill;
    logic b_drain;

    // ====================
    // Arbitration
    // ====================

    // AW only when AR idle or AR won last time
    assign sel_aw    = aw_valid_i & (~ar_valid_i | ~last_aw_q);
    assign arb_valid = ar_valid_i | aw_valid_i;

    assign arb_req.ax    = sel_aw ? aw_i : ar_i;
    assign arb_req.write = sel_aw;

    assign ar_ready_o = spill_ready & ~sel_aw;
    assign aw_ready_o = spill_ready & sel_aw;

    // Reset value makes AR the first winner
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_aw_q <= 1'b1;
        end else if (arb_valid && spill_ready) begin
            last_aw_q <= sel_aw;
        end
    end

    // ====================
    // Spill register
    // ====================

    assign spill_ready = ~a_full_q | ~b_full_q;

    assign a_fill  = arb_valid & spill_ready;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~req_ready_i;
    assign b_drain = b_full_q & req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            a_full_q <= a_fill | (a_full_q & ~a_drain);
            b_full_q <= b_fill | (b_full_q & ~b_drain);
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= arb_req;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

    // Older entry sits in B whenever B is occupied
    assign req_valid_o = a_full_q | b_full_q;
    assign req_o       = b_full_q ? b_data_q : a_data_q;

endmodule

/* hdl/hyper_axi_front.sv */
/* HyperBus front end with a simplified AXI slave port, one transfer at a time.
   Connects AXI-style request and beat streams to the PHY descriptor and streams. */

`timescale 1ns/100ps

module hyper_axi_front (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // AXI side
    input  hyper_axi_pkg::ax_t        ar_i,
    input  logic                      ar_valid_i,
    output logic                      ar_ready_o,

    input  hyper_axi_pkg::ax_t        aw_i,
    input  logic                      aw_valid_i,
    output logic                      aw_ready_o,

    input  hyper_axi_pkg::w_beat_t    w_i,
    input  logic                      w_valid_i,
    output logic                      w_ready_o,

    output hyper_axi_pkg::r_beat_t    r_o,
    output logic                      r_valid_o,
    input  logic                      r_ready_i,

    output hyper_axi_pkg::resp_t      b_resp_o,
    output logic                      b_valid_o,
    input  logic                      b_ready_i,

    // PHY side
    input  hyper_phy_pkg::rx_t        rx_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,

    output hyper_phy_pkg::tx_t        tx_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,

    input  logic                      b_error_i,
    input  logic                      phy_b_valid_i,
    output logic                      phy_b_ready_o,

    output hyper_phy_pkg::trans_t     trans_o,
    output logic [hyper_phy_pkg::NumChips-1:0] trans_cs_o,
    output logic                      trans_valid_o,
    input  logic                      trans_ready_i,

    // Configuration and status
    input  hyper_phy_pkg::chip_rule_t [hyper_phy_pkg::NumChips-1:0] chip_rules_i,
    input  logic [4:0]                addr_mask_msb_i,
    input  logic                      addr_space_i,
    output logic                      trans_active_o
);

    import hyper_axi_pkg::*;
    import hyper_phy_pkg::*;

    req_t    req;
    logic    req_valid;
    logic    req_ready;
    logic    trans_handshake;

    logic    active;
    logic    wready;
    logic    read_done;
    logic    write_resp_done;
    logic    tx_done;

    w_beat_t wf_data;
    logic    wf_valid;
    r_beat_t rf_in;

    // ====================
    // Request path
    // ====================

    hyper_ax_arbiter i_ax_arbiter (
        .clk_i,
        .rst_ni,
        .ar_i,
        .ar_valid_i,
        .ar_ready_o,
        .aw_i,
        .aw_valid_i,
        .aw_ready_o,
        .req_o       ( req       ),
        .req_valid_o ( req_valid ),
        .req_ready_i ( req_ready )
    );

    // Hold the request back while a transfer is on the bus
    assign trans_valid_o   = req_valid & ~active;
    assign req_ready       = trans_ready_i & ~active;
    assign trans_handshake = trans_valid_o & trans_ready_i;

    hyper_trans_mapper i_trans_mapper (
        .req_i           ( req ),
        .chip_rules_i,
        .addr_mask_msb_i,
        .addr_space_i,
        .trans_o,
        .trans_cs_o
    );

    // ====================
    // Write path
    // ====================

    hyper_stream_fifo #(
        .Depth ( 8        ),
        .T     ( w_beat_t )
    ) i_w_fifo (
        .clk_i,
        .rst_ni,
        .data_i  ( w_i                 ),
        .valid_i ( w_valid_i           ),
        .ready_o ( w_ready_o           ),
        .data_o  ( wf_data             ),
        .valid_o ( wf_valid            ),
        .ready_i ( tx_ready_i & wready )
    );

    assign tx_o.data  = wf_data.data;
    assign tx_o.strb  = wf_data.strb;
    assign tx_o.last  = wf_data.last;
    assign tx_valid_o = wf_valid & wready;

    // ====================
    // Read path
    // ====================

    assign rf_in.data = rx_i.data;
    assign rf_in.resp = rx_i.error ? RespSlvErr : RespOkay;
    assign rf_in.last = rx_i.last;

    hyper_stream_fifo #(
        .Depth ( 2        ),
        .T     ( r_beat_t )
    ) i_r_fifo (
        .clk_i,
        .rst_ni,
        .data_i  ( rf_in      ),
        .valid_i ( rx_valid_i ),
        .ready_o ( rx_ready_o ),
        .data_o  ( r_o        ),
        .valid_o ( r_valid_o  ),
        .ready_i ( r_ready_i  )
    );

    // Write response passes straight through
    assign b_valid_o     = phy_b_valid_i;
    assign phy_b_ready_o = b_ready_i;
    assign b_resp_o      = b_error_i ? RespSlvErr : RespOkay;

    // ====================
    // Transfer status
    // ====================

    assign read_done       = rx_valid_i & rx_ready_o & rx_i.last;
    assign write_resp_done = phy_b_valid_i & b_ready_i;
    assign tx_done         = tx_valid_o & tx_ready_i & tx_o.last;

    hyper_trans_status i_trans_status (
        .clk_i,
        .rst_ni,
        .trans_start_i     ( trans_handshake ),
        .trans_write_i     ( req.write       ),
        .read_done_i       ( read_done       ),
        .write_resp_done_i ( write_resp_done ),
        .tx_done_i         ( tx_done         ),
        .active_o          ( active          ),
        .wready_o          ( wready          )
    );

    assign trans_active_o = active;

endmodule

/* hdl/hyper_axi_pkg.sv */
/* AXI-side widths and beat types of the HyperBus front end.
   Imported by the front end modules and by the testbench. */

package hyper_axi_pkg;

    // ====================
    // Widths
    // ====================

    // PHY count sets the full beat width, 16 bits per PHY
    localparam int unsigned NumPhys   = 2;
    localparam int unsigned DataWidth = 16 * NumPhys;
    localparam int unsigned StrbWidth = DataWidth / 8;
    localparam int unsigned AddrWidth = 32;

    // ====================
    // Base types
    // ====================

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [StrbWidth-1:0] strb_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [7:0]           len_t;
    typedef logic [2:0]           size_t;
    typedef logic [1:0]           resp_t;

    // Response codes
    localparam resp_t RespOkay   = 2'd0;
    localparam resp_t RespSlvErr = 2'd2;

    // ====================
    // Channel beats
    // ====================

    // Address request, len is beats minus one
    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

endpackage

/* hdl/hyper_phy_pkg.sv */
/* PHY-side transaction descriptor, stream beats and chip rules.
   Shared by the front end, its mapper and the testbench PHY model. */

package hyper_phy_pkg;

    // ====================
    // Chips and bursts
    // ====================

    localparam int unsigned NumChips     = 2;
    localparam int unsigned ChipSelWidth = (NumChips > 1) ? $clog2(NumChips) : 1;

    // Word-count field of a descriptor
    localparam int unsigned BurstWidth = 16;

    typedef logic [BurstWidth-1:0]   blen_t;
    typedef logic [ChipSelWidth-1:0] chip_idx_t;

    // ====================
    // Descriptor
    // ====================

    // One HyperBus transaction, burst counted in 16-bit words
    typedef struct packed {
        logic                 write;
        logic                 burst_type;
        logic                 address_space;
        hyper_axi_pkg::addr_t address;
        blen_t                burst;
    } trans_t;

    // ====================
    // Stream beats
    // ====================

    typedef struct packed {
        hyper_axi_pkg::data_t data;
        hyper_axi_pkg::strb_t strb;
        logic                 last;
    } tx_t;

    typedef struct packed {
        hyper_axi_pkg::data_t data;
        logic                 error;
        logic                 last;
    } rx_t;

    // Half-open range [start_addr, end_addr) mapped to one chip
    typedef struct packed {
        chip_idx_t            idx;
        hyper_axi_pkg::addr_t start_addr;
        hyper_axi_pkg::addr_t end_addr;
    } chip_rule_t;

    // Arbitrated request waiting for the bus
    typedef struct packed {
        hyper_axi_pkg::ax_t ax;
        logic               write;
    } req_t;

endpackage

/* hdl/hyper_stream_fifo.sv */
/* Registered circular FIFO for valid/ready streams, no fall-through.
   The payload type is a parameter so write and read beats share it. */

`timescale 1ns/100ps

module hyper_stream_fifo #(
    parameter int unsigned Depth = 8,
    parameter type         T     = logic
) (
    input  logic clk_i,
    input  logic rst_ni,

    input  T     data_i,
    input  logic valid_i,
    output logic ready_o,

    output T     data_o,
    output logic valid_o,
    input  logic ready_i
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push;
    logic                pop;
    T                    mem_q [Depth];

    // Pointer increment with wrap at the last slot
    function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign ready_o = (count_q != CntWidth'(Depth));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* hdl/hyper_trans_mapper.sv */
/* Combinational mapping of the held request onto a HyperBus descriptor,
   with chip-select decode, address masking and word burst length. */

`timescale 1ns/100ps

module hyper_trans_mapper (
    input  hyper_phy_pkg::req_t       req_i,
    input  hyper_phy_pkg::chip_rule_t [hyper_phy_pkg::NumChips-1:0] chip_rules_i,
    input  logic [4:0]                addr_mask_msb_i,
    input  logic                      addr_space_i,
    output hyper_phy_pkg::trans_t     trans_o,
    output logic [hyper_phy_pkg::NumChips-1:0] trans_cs_o
);

    import hyper_axi_pkg::*;
    import hyper_phy_pkg::*;

    chip_idx_t chip_idx;
    logic      rule_hit;
    addr_t     addr_mask;
    blen_t     beats;

    // ====================
    // Chip select
    // ====================

    // First matching rule wins, chip 0 when nothing matches
    always_comb begin
        chip_idx = '0;
        rule_hit = 1'b0;
        for (int unsigned i = 0; i < NumChips; i++) begin
            if (!rule_hit &&
                (req_i.ax.addr >= chip_rules_i[i].start_addr) &&
                (req_i.ax.addr <  chip_rules_i[i].end_addr)) begin
                chip_idx = chip_rules_i[i].idx;
                rule_hit = 1'b1;
            end
        end
    end

    always_comb begin
        trans_cs_o           = '0;
        trans_cs_o[chip_idx] = 1'b1;
    end

    // ====================
    // Descriptor fields
    // ====================

    // Clear address bits at and above the mask MSB
    assign addr_mask = ~({AddrWidth{1'b1}} << addr_mask_msb_i);

    // Full-width beats only, each beat is NumPhys words
    assign beats = blen_t'(req_i.ax.len) + blen_t'(1);

    assign trans_o.write         = req_i.write;
    // Linear burst, wrapping is not supported
    assign trans_o.burst_type    = 1'b1;
    assign trans_o.address_space = addr_space_i;
    assign trans_o.address       = (req_i.ax.addr & addr_mask) >> NumPhys;
    assign trans_o.burst         = beats << (NumPhys - 1);

endmodule

/* hdl/hyper_trans_status.sv */
/* Transfer tracker holding the bus-active and write-enable flags.
   A start in the same cycle as a done event leaves the flag set. */

`timescale 1ns/100ps

module hyper_trans_status (
    input  logic clk_i,
    input  logic rst_ni,

    input  logic trans_start_i,
    input  logic trans_write_i,
    input  logic read_done_i,
    input  logic write_resp_done_i,
    input  logic tx_done_i,

    output logic active_o,
    output logic wready_o
);

    logic active_d;
    logic active_q;
    logic wready_d;
    logic wready_q;

    // Clear first so a start overrides it
    always_comb begin
        active_d = active_q;
        wready_d = wready_q;
        if (read_done_i || write_resp_done_i) begin
            active_d = 1'b0;
        end
        if (trans_start_i) begin
            active_d = 1'b1;
        end
        if (tx_done_i) begin
            wready_d = 1'b0;
        end
        if (trans_start_i && trans_write_i) begin
            wready_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            wready_q <= 1'b0;
        end else begin
            active_q <= active_d;
            wready_q <= wready_d;
        end
    end

    assign active_o = active_q;
    assign wready_o = wready_q;

endmodule

/* hyper_axi_front.f */
hdl/hyper_axi_pkg.sv
hdl/hyper_phy_pkg.sv
hdl/hyper_ax_arbiter.sv
hdl/hyper_trans_mapper.sv
hdl/hyper_stream_fifo.sv
hdl/hyper_trans_status.sv
hdl/hyper_axi_front.sv
dv/tb_hyper_axi_front.sv
